/* src/lsu_defs.svh */
// width macros for address, data, byte enables and event counters
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

`define LSU_ADDR_W 32   // byte address
`define LSU_DATA_W 32   // one bus word
`define LSU_BE_W   4    // one enable per byte lane

////////////////////////////////////////////////////////////
// performance counters
////////////////////////////////////////////////////////////

`define LSU_CNT_W  16   // wraps, no saturation

`endif

/* src/lsu_pkg.sv */
// shared types: access size, controller state, counter value
`include "lsu_defs.svh"

package lsu_pkg;

  ////////////////////////////////////////////////////////////
  // access size, same encoding as the core's data type
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////////////////////////
  // controller states
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // ready for a command
    REQ_P0  = 3'd1,  // first part on the bus
    WAIT_P0 = 3'd2,  // first part granted, waiting rvalid
    REQ_P1  = 3'd3,  // second word of a misaligned access
    WAIT_P1 = 3'd4,
    RESP    = 3'd5   // one-cycle response pulse
  } lsu_state_e;

  // event counter value
  typedef logic [`LSU_CNT_W-1:0] lsu_cnt_t;

endpackage

/* src/lsu_ctrl_fsm.sv */
// load-store controller FSM: command capture, bus sequencing, response and error
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_ctrl_fsm import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // command side
  input  logic                   cmd_valid_i,
  input  logic                   cmd_we_i,
  input  lsu_size_e              cmd_size_i,
  input  logic                   cmd_sign_ext_i,
  input  logic [`LSU_ADDR_W-1:0] cmd_addr_i,
  input  logic [`LSU_DATA_W-1:0] cmd_wdata_i,
  output logic                   cmd_ready_o,
  output logic                   busy_o,
  // memory handshake
  output logic                   data_req_o,
  output logic                   data_we_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  // data path control
  input  logic                   misaligned_i,    // from lane aligner
  output logic                   part_sel_o,      // 1 while second word is on the bus
  output logic                   rvalid_p0_o,
  output logic                   rvalid_last_o,
  // response and perf strobes
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output logic                   gnt_load_o,
  output logic                   gnt_store_o,
  // registered command fields
  output lsu_size_e              size_q_o,
  output logic                   sign_ext_q_o,
  output logic [`LSU_ADDR_W-1:0] addr_q_o,
  output logic [`LSU_DATA_W-1:0] wdata_q_o
);

  lsu_state_e state_q, state_d;
  logic       we_q;
  logic       err_q;     // sticky over all beats of the command
  logic       accept;
  logic       in_wait;

  assign accept  = cmd_valid_i & cmd_ready_o;
  assign in_wait = (state_q == WAIT_P0) | (state_q == WAIT_P1);

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = REQ_P0;
      REQ_P0:  if (data_gnt_i) state_d = WAIT_P0;
      WAIT_P0: if (data_rvalid_i) state_d = misaligned_i ? REQ_P1 : RESP;
      REQ_P1:  if (data_gnt_i) state_d = WAIT_P1;
      WAIT_P1: if (data_rvalid_i) state_d = RESP;
      RESP:    state_d = IDLE;   // pulse done, back to ready
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) err_q <= 1'b0;   // fresh command
      else if (in_wait && data_rvalid_i) err_q <= err_q | data_err_i;
    end
  end

  // command fields, sampled once at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q         <= cmd_we_i;
      size_q_o     <= cmd_size_i;
      sign_ext_q_o <= cmd_sign_ext_i;
      addr_q_o     <= cmd_addr_i;
      wdata_q_o    <= cmd_wdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////
  assign cmd_ready_o   = (state_q == IDLE);
  assign busy_o        = (state_q != IDLE);          // includes RESP cycle
  assign data_req_o    = (state_q == REQ_P0) | (state_q == REQ_P1);
  assign data_we_o     = we_q;
  assign part_sel_o    = (state_q == REQ_P1) | (state_q == WAIT_P1);
  assign rvalid_p0_o   = (state_q == WAIT_P0) & data_rvalid_i;
  assign rvalid_last_o = data_rvalid_i &
                         (((state_q == WAIT_P0) & ~misaligned_i) | (state_q == WAIT_P1));
  assign rsp_valid_o   = (state_q == RESP);
  assign rsp_err_o     = (state_q == RESP) & err_q;

  // granted transactions by direction, counts both parts
  assign gnt_load_o    = data_req_o & data_gnt_i & ~data_we_o;
  assign gnt_store_o   = data_req_o & data_gnt_i & data_we_o;

  // back-pressure rule, request and its fields hold until granted
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(addr_q_o) && $stable(wdata_q_o)
      && $stable(size_q_o) && $stable(data_we_o) && $stable(part_sel_o))
    else $error("request fields changed before grant");

  // memory must not answer without an outstanding granted request
  a_rvalid_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_rvalid_i |-> in_wait)
    else $error("rvalid outside a wait state");

endmodule

/* src/lsu_wdata_align.sv */
// address, byte enable and write lane placement for each part of an access
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_wdata_align import lsu_pkg::*; (
  input  logic [`LSU_ADDR_W-1:0] addr_q_i,
  input  lsu_size_e              size_q_i,
  input  logic [`LSU_DATA_W-1:0] wdata_q_i,
  input  logic                   part_sel_i,     // 0 first word, 1 next word
  output logic [`LSU_ADDR_W-1:0] data_addr_o,    // always word aligned
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  output logic                   misaligned_o
);

  logic [1:0]                 offset;
  logic [`LSU_ADDR_W-3:0]     word_addr;
  logic [`LSU_BE_W-1:0]       be_base;     // enables before the shift
  logic [2*`LSU_BE_W-1:0]     be_pair;     // enables over two words
  logic [2*`LSU_DATA_W-1:0]   wdata_pair;

  assign offset = addr_q_i[1:0];

  ////////////////////////////////////////////////////////////
  // misalignment, access crosses a word boundary
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (size_q_i)
      SIZE_WORD: misaligned_o = (offset != 2'b00);
      SIZE_HALF: misaligned_o = (offset == 2'b11);
      default:   misaligned_o = 1'b0;   // a byte never crosses
    endcase
  end

  // word address, next word for part 1
  assign word_addr   = addr_q_i[`LSU_ADDR_W-1:2] + (`LSU_ADDR_W-2)'(part_sel_i);
  assign data_addr_o = {word_addr, 2'b00};

  ////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (size_q_i)
      SIZE_BYTE: be_base = 4'b0001;
      SIZE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b1111;
    endcase
  end

  // shift over a double word, upper half belongs to part 1
  assign be_pair   = {{`LSU_BE_W{1'b0}}, be_base} << offset;
  assign data_be_o = part_sel_i ? be_pair[2*`LSU_BE_W-1:`LSU_BE_W]
                                : be_pair[`LSU_BE_W-1:0];

  ////////////////////////////////////////////////////////////
  // write lanes
  ////////////////////////////////////////////////////////////
  // rotate left by offset bytes, same lanes for both parts
  // the enables pick out the valid bytes in each word
  assign wdata_pair   = {wdata_q_i, wdata_q_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_pair[2*`LSU_DATA_W-1:`LSU_DATA_W];

endmodule

/* src/lsu_rdata_extend.sv */
// read data path: first part capture, merge of both parts, sign or zero extension
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_rdata_extend import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   rvalid_p0_i,     // first part beat
  input  logic                   rvalid_last_i,   // final beat of the command
  input  logic [`LSU_ADDR_W-1:0] addr_q_i,        // only the byte offset matters
  input  lsu_size_e              size_q_i,
  input  logic                   sign_ext_q_i,
  input  logic                   misaligned_i,
  output logic [`LSU_DATA_W-1:0] rsp_rdata_o
);

  logic [`LSU_DATA_W-1:0]   p0_q;        // held first word
  logic [`LSU_DATA_W-1:0]   lo_word;
  logic [2*`LSU_DATA_W-1:0] pair_shr;
  logic [`LSU_DATA_W-1:0]   merged;
  logic [`LSU_DATA_W-1:0]   extended;

  always_ff @(posedge clk_i) begin
    if (rvalid_p0_i) p0_q <= data_rdata_i;
  end

  ////////////////////////////////////////////////////////////
  // merge
  ////////////////////////////////////////////////////////////
  // part 0 gives the low bytes, current beat the rest
  // aligned access uses the current beat for both halves
  assign lo_word  = misaligned_i ? p0_q : data_rdata_i;
  assign pair_shr = {data_rdata_i, lo_word} >> {addr_q_i[1:0], 3'b000};
  assign merged   = pair_shr[`LSU_DATA_W-1:0];

  ////////////////////////////////////////////////////////////
  // extension by size
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (size_q_i)
      SIZE_BYTE: extended = {{(`LSU_DATA_W-8){sign_ext_q_i & merged[7]}}, merged[7:0]};
      SIZE_HALF: extended = {{(`LSU_DATA_W-16){sign_ext_q_i & merged[15]}}, merged[15:0]};
      default:   extended = merged;   // full word, nothing to fill
    endcase
  end

  // result register, loaded on the final beat only
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_rdata_o <= '0;
    end else if (rvalid_last_i) begin
      rsp_rdata_o <= extended;
    end
  end

  // a split access needs two separate beats before the result
  a_split_beats: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    misaligned_i |-> !(rvalid_last_i && rvalid_p0_i))
    else $error("final beat merged with first part of a split access");

endmodule

/* src/lsu_event_counter.sv */
// wrapping event counter for granted loads or stores
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_event_counter import lsu_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     event_i,   // one strobe per granted transaction
  output lsu_cnt_t count_o
);

  lsu_cnt_t count_q;
  lsu_cnt_t count_d;

  ////////////////////////////////////////////////////////////
  // increment, wraps to zero past all ones
  ////////////////////////////////////////////////////////////
  always_comb begin
    count_d = count_q;
    if (event_i) begin
      count_d = count_q + `LSU_CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign count_o = count_q;   // visible one cycle after the event

endmodule

/* src/lsu_top.sv */
// data memory access unit top: controller, lane aligner, read extend, perf counters
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // command
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  logic                   cmd_we_i,
  input  lsu_size_e              cmd_size_i,
  input  logic                   cmd_sign_ext_i,
  input  logic [`LSU_ADDR_W-1:0] cmd_addr_i,
  input  logic [`LSU_DATA_W-1:0] cmd_wdata_i,
  // response
  output logic                   rsp_valid_o,
  output logic [`LSU_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic                   busy_o,
  // data memory, request/grant/rvalid
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic                   data_we_o,
  output logic [`LSU_BE_W-1:0]   data_be_o,
  output logic [`LSU_ADDR_W-1:0] data_addr_o,
  output logic [`LSU_DATA_W-1:0] data_wdata_o,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i,
  // perf counters
  output lsu_cnt_t               perf_load_cnt_o,
  output lsu_cnt_t               perf_store_cnt_o
);

  logic                   misaligned;
  logic                   part_sel;
  logic                   rvalid_p0;
  logic                   rvalid_last;
  logic                   gnt_load;
  logic                   gnt_store;
  lsu_size_e              size_q;
  logic                   sign_ext_q;
  logic [`LSU_ADDR_W-1:0] addr_q;
  logic [`LSU_DATA_W-1:0] wdata_q;

  ////////////////////////////////////////////////////////////
  // controller
  ////////////////////////////////////////////////////////////
  lsu_ctrl_fsm ctrl_fsm_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .cmd_valid_i    ( cmd_valid_i    ),
    .cmd_we_i       ( cmd_we_i       ),
    .cmd_size_i     ( cmd_size_i     ),
    .cmd_sign_ext_i ( cmd_sign_ext_i ),
    .cmd_addr_i     ( cmd_addr_i     ),
    .cmd_wdata_i    ( cmd_wdata_i    ),
    .cmd_ready_o    ( cmd_ready_o    ),
    .busy_o         ( busy_o         ),
    .data_req_o     ( data_req_o     ),
    .data_we_o      ( data_we_o      ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_err_i     ( data_err_i     ),
    .misaligned_i   ( misaligned     ),
    .part_sel_o     ( part_sel       ),
    .rvalid_p0_o    ( rvalid_p0      ),
    .rvalid_last_o  ( rvalid_last    ),
    .rsp_valid_o    ( rsp_valid_o    ),
    .rsp_err_o      ( rsp_err_o      ),
    .gnt_load_o     ( gnt_load       ),   // to load counter
    .gnt_store_o    ( gnt_store      ),   // to store counter
    .size_q_o       ( size_q         ),
    .sign_ext_q_o   ( sign_ext_q     ),
    .addr_q_o       ( addr_q         ),
    .wdata_q_o      ( wdata_q        )
  );

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////
  lsu_wdata_align wdata_align_i (
    .addr_q_i     ( addr_q       ),
    .size_q_i     ( size_q       ),
    .wdata_q_i    ( wdata_q      ),
    .part_sel_i   ( part_sel     ),
    .data_addr_o  ( data_addr_o  ),
    .data_be_o    ( data_be_o    ),
    .data_wdata_o ( data_wdata_o ),
    .misaligned_o ( misaligned   )
  );

  lsu_rdata_extend rdata_extend_i (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .data_rdata_i  ( data_rdata_i ),
    .rvalid_p0_i   ( rvalid_p0    ),
    .rvalid_last_i ( rvalid_last  ),
    .addr_q_i      ( addr_q       ),
    .size_q_i      ( size_q       ),
    .sign_ext_q_i  ( sign_ext_q   ),
    .misaligned_i  ( misaligned   ),
    .rsp_rdata_o   ( rsp_rdata_o  )
  );

  ////////////////////////////////////////////////////////////
  // perf counters, one tick per granted transaction
  ////////////////////////////////////////////////////////////
  lsu_event_counter load_cnt_i (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .event_i ( gnt_load        ),
    .count_o ( perf_load_cnt_o )
  );

  lsu_event_counter store_cnt_i (
    .clk_i   ( clk_i            ),
    .rst_n_i ( rst_n_i          ),
    .event_i ( gnt_store        ),
    .count_o ( perf_store_cnt_o )
  );

endmodule

/* sim/tb_lsu_mem.sv */
// bus memory model: request/grant/rvalid answers, random delays, error word
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu_mem (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [`LSU_BE_W-1:0]   be_i,
  input  logic [`LSU_ADDR_W-1:0] addr_i,
  input  logic [`LSU_DATA_W-1:0] wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   err_o
);

  logic [`LSU_DATA_W-1:0] mem [0:255];   // 256 words, index addr[9:2]
  logic [31:0]            lcg_q;
  logic [1:0]             gnt_dly;       // cycles of req before grant
  logic [1:0]             wait_cnt;
  logic [1:0]             rv_cnt;        // extra cycles before rvalid
  logic                   pending;       // granted, rvalid not yet sent
  logic [7:0]             idx_q;
  int                     b;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // fill pattern, every byte depends on the word index
  initial begin
    for (int i = 0; i < 256; i++)
      mem[i] = {~8'(i), 8'(i) ^ 8'h5a, 8'(i), 8'(i) + 8'h81};
  end

  assign gnt_o = req_i && (wait_cnt == gnt_dly);

  ////////////////////////////////////////////////////////////
  // grant, write, delayed rvalid
  ////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      lcg_q    <= 32'd45285;
      gnt_dly  <= 2'd0;
      wait_cnt <= 2'd0;
      rv_cnt   <= 2'd0;
      pending  <= 1'b0;
      idx_q    <= 8'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      err_o    <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      if (gnt_o) begin
        idx_q    <= addr_i[9:2];
        pending  <= 1'b1;
        rv_cnt   <= lcg_q[31:30];   // upper bits, longer period
        gnt_dly  <= lcg_q[29:28];   // for the next request
        lcg_q    <= lcg_next(lcg_q);
        wait_cnt <= 2'd0;
        if (we_i) begin
          for (b = 0; b < `LSU_BE_W; b++)
            if (be_i[b]) mem[addr_i[9:2]][8*b +: 8] = wdata_i[8*b +: 8];
        end
      end else if (req_i) begin
        wait_cnt <= wait_cnt + 2'd1;
      end
      if (pending) begin
        if (rv_cnt == 2'd0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[idx_q];
          err_o    <= (idx_q == 8'hff);   // injected bus error
          pending  <= 1'b0;
        end else begin
          rv_cnt <= rv_cnt - 2'd1;
        end
      end
    end
  end

endmodule

/* sim/tb_lsu.sv */
// testbench top with clock, reset, directed load/store tests, compare tasks and summary
`timescale 1ns/1ps
`include "lsu_defs.svh"

module tb_lsu import lsu_pkg::*;;

  logic                   clk;
  logic                   rst_n;
  logic                   cmd_valid, cmd_ready, cmd_we, cmd_sign_ext;
  lsu_size_e              cmd_size;
  logic [`LSU_ADDR_W-1:0] cmd_addr;
  logic [`LSU_DATA_W-1:0] cmd_wdata, rsp_rdata, data_wdata, data_rdata;
  logic                   rsp_valid, rsp_err, busy;
  logic                   data_req, data_gnt, data_rvalid, data_we, data_err;
  logic [`LSU_BE_W-1:0]   data_be;
  logic [`LSU_ADDR_W-1:0] data_addr;
  lsu_cnt_t               perf_load_cnt, perf_store_cnt;

  int                     mism_cnt;
  int                     fail_cnt;
  lsu_cnt_t               exp_loads, exp_stores;   // a split access counts twice
  logic [7:0]             ref_mem [0:1023];        // byte image of the model memory

  always #50 clk = ~clk;

  lsu_top dut_i (
    .clk_i (clk), .rst_n_i (rst_n),
    .cmd_valid_i (cmd_valid), .cmd_ready_o (cmd_ready), .cmd_we_i (cmd_we),
    .cmd_size_i (cmd_size), .cmd_sign_ext_i (cmd_sign_ext),
    .cmd_addr_i (cmd_addr), .cmd_wdata_i (cmd_wdata),
    .rsp_valid_o (rsp_valid), .rsp_rdata_o (rsp_rdata), .rsp_err_o (rsp_err),
    .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_we_o (data_we), .data_be_o (data_be), .data_addr_o (data_addr),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata), .data_err_i (data_err),
    .perf_load_cnt_o (perf_load_cnt), .perf_store_cnt_o (perf_store_cnt)
  );

  tb_lsu_mem mem_i (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (data_req), .we_i (data_we),
    .be_i (data_be), .addr_i (data_addr), .wdata_i (data_wdata),
    .gnt_o (data_gnt), .rvalid_o (data_rvalid), .rdata_o (data_rdata), .err_o (data_err)
  );

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////
  task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cnt(input string name, input lsu_cnt_t got, input lsu_cnt_t exp);
    if (got !== exp) begin
      mism_cnt++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////
  function automatic logic crosses_word(input lsu_size_e size, input logic [1:0] off);
    return (size == SIZE_WORD && off != 2'd0) || (size == SIZE_HALF && off == 2'd3);
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    return (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
  endfunction

  // lanes of one bus word that hold bytes of the access
  function automatic logic [3:0] expected_be(input lsu_size_e size, input logic [31:0] addr,
                                             input int part);
    logic [3:0] be;
    int         j;
    int         first;
    int         pos;
    be    = '0;
    first = int'(addr[1:0]);
    for (j = 0; j < 4; j++) begin
      pos   = 4 * part + j;   // byte position from the first aligned word
      be[j] = (pos >= first) && (pos < first + size_bytes(size));
    end
    return be;
  endfunction

  // little endian gather from the byte image and extension
  function automatic logic [31:0] expected_load(input lsu_size_e size, input logic sign,
                                                input logic [31:0] addr);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < size_bytes(size); k++)
      v[8*k +: 8] = ref_mem[int'(addr[9:0]) + k];
    case (size)
      SIZE_BYTE: if (sign && v[7]) v[31:8] = '1;
      SIZE_HALF: if (sign && v[15]) v[31:16] = '1;
      default: ;
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // one command with handshake and bus checks
  ////////////////////////////////////////////////////////////
  task automatic run_access(input logic we, input lsu_size_e size, input logic sign,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int          cyc;
    int          grants;
    int          k;
    logic        split;
    logic        done;
    logic        hold_q;     // request without grant at the last sample
    logic        rvalid_q;
    logic [31:0] addr_prev;
    logic [31:0] wdata_prev;
    logic [3:0]  be_prev;
    split    = crosses_word(size, addr[1:0]);
    rdata    = '0;
    err      = 1'b0;
    cyc      = 0;
    while (!cmd_ready && cyc < 20) begin
      @(negedge clk);
      cyc++;
    end
    if (!cmd_ready) begin
      fail_cnt++;
      $display("timeout: unit never became ready for access at %h", addr);
    end
    cmd_valid    = 1'b1;
    cmd_we       = we;
    cmd_size     = size;
    cmd_sign_ext = sign;
    cmd_addr     = addr;
    cmd_wdata    = wdata;
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd_addr  = ~addr;    // fields must be registered by now
    cmd_wdata = ~wdata;
    check_flag("data_req_o", data_req, 1'b1);   // first request right after acceptance
    grants     = 0;
    done       = 1'b0;
    hold_q     = 1'b0;
    rvalid_q   = 1'b0;
    addr_prev  = '0;
    wdata_prev = '0;
    be_prev    = '0;
    cyc        = 0;
    while (!done && cyc < 100) begin
      check_flag("busy_o", busy, 1'b1);
      check_flag("cmd_ready_o", cmd_ready, 1'b0);
      if (hold_q) begin   // back-pressure holds every request field
        check_flag("data_req_o", data_req, 1'b1);
        check_data("data_addr_o", data_addr, addr_prev);
        check_data("data_wdata_o", data_wdata, wdata_prev);
        check_data("data_be_o", 32'(data_be), 32'(be_prev));
      end
      if (data_req && data_gnt) begin
        check_data("data_addr_o", data_addr, {addr[31:2], 2'b00} + 32'(4 * grants));
        check_data("data_be_o", 32'(data_be), 32'(expected_be(size, addr, grants)));
        check_flag("data_we_o", data_we, we);
        grants++;
      end
      if (rsp_valid) begin
        check_flag("data_rvalid_i before rsp_valid_o", rvalid_q, 1'b1);
        rdata = rsp_rdata;
        err   = rsp_err;
        done  = 1'b1;
      end else begin
        hold_q     = data_req && !data_gnt;
        addr_prev  = data_addr;
        wdata_prev = data_wdata;
        be_prev    = data_be;
        rvalid_q   = data_rvalid;
        @(negedge clk);
        cyc++;
      end
    end
    if (!done) begin
      fail_cnt++;
      $display("timeout: no response for access at %h", addr);
    end
    check_data("grant count", 32'(grants), split ? 32'd2 : 32'd1);
    if (we) begin
      exp_stores = exp_stores + lsu_cnt_t'(split ? 2 : 1);
      for (k = 0; k < size_bytes(size); k++)
        ref_mem[int'(addr[9:0]) + k] = wdata[8*k +: 8];
    end else begin
      exp_loads = exp_loads + lsu_cnt_t'(split ? 2 : 1);
    end
    @(negedge clk);   // past the response cycle
    check_flag("rsp_valid_o", rsp_valid, 1'b0);   // single cycle pulse
    check_flag("busy_o", busy, 1'b0);
    check_flag("cmd_ready_o", cmd_ready, 1'b1);
  endtask

  task automatic store_value(input lsu_size_e size, input logic [31:0] addr,
                             input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    run_access(1'b1, size, 1'b0, addr, wdata, rd, err);
    check_flag("rsp_err_o", err, 1'b0);
  endtask

  task automatic load_and_compare(input lsu_size_e size, input logic sign,
                                  input logic [31:0] addr);
    logic [31:0] rd;
    logic [31:0] exp;
    logic        err;
    exp = expected_load(size, sign, addr);
    run_access(1'b0, size, sign, addr, 32'h0, rd, err);
    check_data("rsp_rdata_o", rd, exp);
    check_flag("rsp_err_o", err, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_values;
    check_flag("cmd_ready_o", cmd_ready, 1'b1);
    check_flag("busy_o", busy, 1'b0);
    check_flag("data_req_o", data_req, 1'b0);
    check_flag("rsp_valid_o", rsp_valid, 1'b0);
    check_cnt("perf_load_cnt_o", perf_load_cnt, '0);
    check_cnt("perf_store_cnt_o", perf_store_cnt, '0);
  endtask

  task automatic aligned_accesses;
    int   k;
    logic s;
    store_value(SIZE_WORD, 32'h40, 32'h8bad_f00d);
    store_value(SIZE_HALF, 32'h44, 32'hdead_c3a5);   // upper bits must not land
    store_value(SIZE_HALF, 32'h46, 32'h1234_7e81);
    for (k = 0; k < 4; k++)
      store_value(SIZE_BYTE, 32'h48 + 32'(k), 32'hdead_be00 | 32'(8'h39 + 8'(k) * 8'h4d));
    load_and_compare(SIZE_WORD, 1'b0, 32'h40);
    for (k = 0; k < 2; k++) begin
      s = k[0];
      load_and_compare(SIZE_HALF, s, 32'h44);
      load_and_compare(SIZE_HALF, s, 32'h46);
      load_and_compare(SIZE_HALF, s, 32'h41);   // inside one word so no split
      for (int j = 0; j < 4; j++)
        load_and_compare(SIZE_BYTE, s, 32'h48 + 32'(j));
    end
  endtask

  task automatic misaligned_accesses;
    int          off;
    logic [31:0] a;
    for (off = 1; off < 4; off++) begin
      a = 32'h80 + 32'(16 * off + off);
      store_value(SIZE_WORD, a, 32'hc0de_1000 + 32'(off) * 32'h1111_0101);
      load_and_compare(SIZE_WORD, 1'b0, a);
    end
    for (off = 0; off < 4; off++) begin   // only offset 3 splits
      a = 32'hd0 + 32'(8 * off + off);
      store_value(SIZE_HALF, a, 32'h5555_8a61 + 32'(off));
      load_and_compare(SIZE_HALF, 1'b1, a);
      load_and_compare(SIZE_HALF, 1'b0, a);
    end
  endtask

  task automatic error_responses;
    logic [31:0] rd;
    logic        err;
    run_access(1'b0, SIZE_WORD, 1'b0, 32'h3fc, 32'h0, rd, err);
    check_flag("rsp_err_o", err, 1'b1);
    run_access(1'b0, SIZE_BYTE, 1'b1, 32'h3fd, 32'h0, rd, err);
    check_flag("rsp_err_o", err, 1'b1);
    run_access(1'b0, SIZE_WORD, 1'b0, 32'h3fa, 32'h0, rd, err);   // second part hits it
    check_flag("rsp_err_o", err, 1'b1);
    run_access(1'b0, SIZE_WORD, 1'b0, 32'h3fd, 32'h0, rd, err);   // first part hits it
    check_flag("rsp_err_o", err, 1'b1);
    load_and_compare(SIZE_WORD, 1'b0, 32'h3f8);   // neighbour word is clean
  endtask

  task automatic memory_contents;
    for (int w = 0; w < 256; w++)
      check_data($sformatf("memory word %0d", w), mem_i.mem[w],
                 {ref_mem[4*w+3], ref_mem[4*w+2], ref_mem[4*w+1], ref_mem[4*w]});
  endtask

  task automatic perf_counts;
    check_cnt("perf_load_cnt_o", perf_load_cnt, exp_loads);
    check_cnt("perf_store_cnt_o", perf_store_cnt, exp_stores);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_we       = 1'b0;
    cmd_size     = SIZE_WORD;
    cmd_sign_ext = 1'b0;
    cmd_addr     = '0;
    cmd_wdata    = '0;
    mism_cnt     = 0;
    fail_cnt     = 0;
    exp_loads    = '0;
    exp_stores   = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = mem_i.mem[i / 4][8 * (i % 4) +: 8];
    reset_values();
    aligned_accesses();
    misaligned_accesses();
    error_responses();
    memory_contents();
    perf_counts();
    $display("summary: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+src
src/lsu_pkg.sv
src/lsu_ctrl_fsm.sv
src/lsu_wdata_align.sv
src/lsu_rdata_extend.sv
src/lsu_event_counter.sv
src/lsu_top.sv
sim/tb_lsu_mem.sv
sim/tb_lsu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_lsu \
  -Mdir obj_dir -o tb_lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_lsu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
